//--- design/carrierLoopPkg.sv
// ------------------------------
// Carrier loop shared types
// Sample, configuration, status, AXI4-Lite and register map
// ------------------------------

`default_nettype none

package carrierLoopPkg;

  // Complex sample, mixer input and output, oscillator output
  typedef struct packed {
    logic signed [17:0] i;
    logic signed [17:0] q;
  } cplxSample;

  // Loop configuration from the register block
  typedef struct packed {
    logic        invertError;
    logic        zeroError;
    logic        clearAccum;
    logic [4:0]  leadExp;
    logic [4:0]  lagExp;
    logic [31:0] limit;
    logic [15:0] lockCount;
    logic [7:0]  syncThreshold;
  } loopConfig;

  // Status returned for readback
  typedef struct packed {
    logic        carrierLock;
    logic [31:0] lagAccumHigh;
    logic [31:0] freqWord;
  } loopStatus;

  // AXI4-Lite master to slave
  typedef struct packed {
    logic [7:0]  awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        rready;
  } axiLiteReq;

  // AXI4-Lite slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axiLiteRsp;

  localparam logic [1:0] AXI_OKAY = 2'b00;

  // ------------------------------
  // Register offsets
  // ------------------------------
  localparam logic [7:0] REG_CONTROL = 8'h00;
  localparam logic [7:0] REG_GAINS   = 8'h04;
  localparam logic [7:0] REG_LIMIT   = 8'h08;
  localparam logic [7:0] REG_LOCK    = 8'h0C;
  localparam logic [7:0] REG_STATUS  = 8'h10;
  localparam logic [7:0] REG_LAG     = 8'h14;
  localparam logic [7:0] REG_FREQ    = 8'h18;

endpackage

`default_nettype wire

//--- design/loopRegs.sv
// ------------------------------
// Carrier loop register block
// AXI4-Lite slave for loop configuration and status
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module loopRegs
  import carrierLoopPkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire axiLiteReq axiReq,
  output axiLiteRsp      axiRsp,
  input  wire loopStatus status,
  output loopConfig      cfg
);

  // Implemented bits of the writable registers
  localparam logic [31:0] CONTROL_MASK = 32'h0000_0007;
  localparam logic [31:0] GAINS_MASK   = 32'h0000_1F1F;
  localparam logic [31:0] LIMIT_MASK   = 32'hFFFF_FFFF;
  localparam logic [31:0] LOCK_MASK    = 32'h00FF_FFFF;

  logic [31:0] controlReg, gainsReg, limitReg, lockReg;
  logic        awReady, wReady, bValid, arReady, rValid;
  logic        awHeld, wHeld;
  logic [7:0]  awAddr;
  logic [31:0] wData;
  logic [3:0]  wStrb;
  logic [31:0] rData;
  logic        awFire, wFire, arFire, doWrite;
  logic        awHeldNext, wHeldNext, bValidNext, rValidNext;

  function automatic logic [31:0] strobeMerge(input logic [31:0] old,
                                              input logic [31:0] data,
                                              input logic [3:0]  strb,
                                              input logic [31:0] mask);
    logic [31:0] merged;
    int          b;
    merged = old;
    for (b = 0; b < 4; b++) begin
      if (strb[b]) merged[8*b +: 8] = data[8*b +: 8];
    end
    return merged & mask;
  endfunction

  function automatic logic [31:0] readMux(input logic [7:0] addr);
    case (addr)
      REG_CONTROL: return controlReg;
      REG_GAINS:   return gainsReg;
      REG_LIMIT:   return limitReg;
      REG_LOCK:    return lockReg;
      REG_STATUS:  return {31'b0, status.carrierLock};
      REG_LAG:     return status.lagAccumHigh;
      REG_FREQ:    return status.freqWord;
      default:     return 32'h0;
    endcase
  endfunction

  // ------------------------------
  // Handshake state
  // ------------------------------
  assign awFire     = awReady & axiReq.awvalid;
  assign wFire      = wReady & axiReq.wvalid;
  assign arFire     = arReady & axiReq.arvalid;
  // Both halves seen, commit the write
  assign doWrite    = awHeld & wHeld;
  assign awHeldNext = (awHeld | awFire) & ~doWrite;
  assign wHeldNext  = (wHeld | wFire) & ~doWrite;
  assign bValidNext = doWrite | (bValid & ~axiReq.bready);
  assign rValidNext = arFire | (rValid & ~axiReq.rready);

  always_ff @(posedge clk) begin
    if (reset) begin
      awReady <= 1'b0;
      wReady  <= 1'b0;
      arReady <= 1'b0;
      awHeld  <= 1'b0;
      wHeld   <= 1'b0;
      bValid  <= 1'b0;
      rValid  <= 1'b0;
    end else begin
      awHeld  <= awHeldNext;
      wHeld   <= wHeldNext;
      bValid  <= bValidNext;
      rValid  <= rValidNext;
      // No new address until the response has been taken
      awReady <= ~awHeldNext & ~bValidNext;
      wReady  <= ~wHeldNext & ~bValidNext;
      arReady <= ~rValidNext;
    end
  end

  // Captured write address, data and read data
  always_ff @(posedge clk) begin
    if (awFire) awAddr <= axiReq.awaddr;
    if (wFire) begin
      wData <= axiReq.wdata;
      wStrb <= axiReq.wstrb;
    end
    if (arFire) rData <= readMux(axiReq.araddr);
  end

  // ------------------------------
  // Writable registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      controlReg <= '0;
      gainsReg   <= '0;
      limitReg   <= '0;
      lockReg    <= '0;
    end else if (doWrite) begin
      case (awAddr)
        REG_CONTROL: controlReg <= strobeMerge(controlReg, wData, wStrb, CONTROL_MASK);
        REG_GAINS:   gainsReg   <= strobeMerge(gainsReg, wData, wStrb, GAINS_MASK);
        REG_LIMIT:   limitReg   <= strobeMerge(limitReg, wData, wStrb, LIMIT_MASK);
        REG_LOCK:    lockReg    <= strobeMerge(lockReg, wData, wStrb, LOCK_MASK);
        default:     ;
      endcase
    end
  end

  assign axiRsp = '{awready: awReady, wready: wReady, bresp: AXI_OKAY, bvalid: bValid,
                    arready: arReady, rdata: rData, rresp: AXI_OKAY, rvalid: rValid};

  assign cfg = '{invertError:   controlReg[0],
                 zeroError:     controlReg[1],
                 clearAccum:    controlReg[2],
                 leadExp:       gainsReg[4:0],
                 lagExp:        gainsReg[12:8],
                 limit:         limitReg,
                 lockCount:     lockReg[15:0],
                 syncThreshold: lockReg[23:16]};

endmodule

`default_nettype wire

//--- design/loopFilter.sv
// ------------------------------
// Carrier loop filter
// Error adjust, lead/lag filter, frequency word
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module loopFilter
  import carrierLoopPkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              symEn,
  input  wire logic signed [7:0] phaseError,
  input  wire loopConfig         cfg,
  output logic [31:0]            lagAccumHigh,
  output logic [31:0]            freqWord
);

  logic signed [7:0]  adjError;
  logic signed [39:0] errorExt;
  logic signed [39:0] leadTerm;
  logic signed [39:0] lagTerm;
  logic signed [39:0] lagAccum;
  logic signed [39:0] accumSum;
  logic signed [39:0] clampedAccum;
  logic signed [39:0] nextAccum;
  logic signed [39:0] filterSum;
  logic signed [40:0] sumWide;
  logic signed [40:0] posLimit;
  logic signed [40:0] negLimit;

  // Zero, invert or pass the detector error
  always_comb begin
    if (cfg.zeroError) adjError = 8'sd0;
    else if (cfg.invertError) adjError = 8'sd0 - phaseError;
    else adjError = phaseError;
  end

  assign errorExt = {{32{adjError[7]}}, adjError};
  assign leadTerm = errorExt <<< cfg.leadExp;
  assign lagTerm  = errorExt <<< cfg.lagExp;

  // ------------------------------
  // Integrator with clamp
  // ------------------------------
  assign accumSum = lagAccum + lagTerm;
  assign sumWide  = {accumSum[39], accumSum};
  // Limit is in units of 256 integrator LSBs
  assign posLimit = $signed({1'b0, cfg.limit, 8'h00});
  assign negLimit = -posLimit;

  always_comb begin
    if (sumWide > posLimit) clampedAccum = posLimit[39:0];
    else if (sumWide < negLimit) clampedAccum = negLimit[39:0];
    else clampedAccum = accumSum;
  end

  assign nextAccum = cfg.clearAccum ? 40'sd0 : clampedAccum;
  assign filterSum = nextAccum + leadTerm;

  always_ff @(posedge clk) begin
    if (reset) begin
      lagAccum <= '0;
      freqWord <= '0;
    end else begin
      // Clear holds the integrator at zero between symbols too
      if (symEn || cfg.clearAccum) lagAccum <= nextAccum;
      if (symEn) freqWord <= filterSum[39:8];
    end
  end

  assign lagAccumHigh = lagAccum[39:8];

endmodule

`default_nettype wire

//--- design/lockDetector.sv
// ------------------------------
// Carrier lock detector
// Up/down hysteresis counter
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module lockDetector (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        symEn,
  input  wire logic [7:0]  phaseError,
  input  wire logic [15:0] lockCount,
  input  wire logic [7:0]  syncThreshold,
  output logic             carrierLock
);

  logic [7:0]  errMag;
  logic [15:0] lockCounter;
  logic [16:0] countUp;
  logic [16:0] countDown;

  // Magnitude of the raw detector error
  assign errMag    = phaseError[7] ? (~phaseError + 8'd1) : phaseError;
  // Bit 16 flags a wrap in either direction
  assign countUp   = {1'b0, lockCounter} + 17'd1;
  assign countDown = {1'b0, lockCounter} - 17'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      lockCounter <= '0;
      carrierLock <= 1'b0;
    end else if (symEn) begin
      if (errMag > syncThreshold) begin
        if (countDown[16]) begin
          carrierLock <= 1'b0;
          lockCounter <= lockCount;
        end else begin
          lockCounter <= countDown[15:0];
        end
      end else begin
        if (countUp[16]) begin
          carrierLock <= 1'b1;
          lockCounter <= lockCount;
        end else begin
          lockCounter <= countUp[15:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/ncoDds.sv
// ------------------------------
// Numerically controlled oscillator
// Phase accumulator and cos/sin lookup
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module ncoDds
  import carrierLoopPkg::*;
#(
  parameter int SAMPLE_WIDTH = 18,
  parameter int TABLE_BITS   = 10
) (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic [31:0] freqWord,
  output cplxSample        lo
);

  localparam int  TABLE_SIZE = 1 << TABLE_BITS;
  localparam real PI         = 3.14159265358979323846;
  // Full-scale amplitude, 131071 for 18-bit samples
  localparam real AMPLITUDE  = real'((1 << (SAMPLE_WIDTH - 1)) - 1);

  logic [31:0]                   phase;
  logic [TABLE_BITS-1:0]         tableAddr;
  logic signed [SAMPLE_WIDTH-1:0] cosTable [TABLE_SIZE];
  logic signed [SAMPLE_WIDTH-1:0] sinTable [TABLE_SIZE];

  // Round half away from zero
  function automatic int roundReal(input real x);
    if (x >= 0.0) return $rtoi(x + 0.5);
    else return $rtoi(x - 0.5);
  endfunction

  // ------------------------------
  // Lookup tables
  // ------------------------------
  for (genvar k = 0; k < TABLE_SIZE; k++) begin : genTable
    localparam real ANGLE     = 2.0 * PI * k / TABLE_SIZE;
    localparam int  COS_VALUE = roundReal(AMPLITUDE * $cos(ANGLE));
    localparam int  SIN_VALUE = roundReal(AMPLITUDE * $sin(ANGLE));
    assign cosTable[k] = SAMPLE_WIDTH'(COS_VALUE);
    assign sinTable[k] = SAMPLE_WIDTH'(SIN_VALUE);
  end

  // Free-running phase, one step per clock
  always_ff @(posedge clk) begin
    if (reset) phase <= '0;
    else phase <= phase + freqWord;
  end

  assign tableAddr = phase[31 -: TABLE_BITS];

  // Output one cycle behind the phase
  always_ff @(posedge clk) begin
    lo.i <= cosTable[tableAddr];
    lo.q <= sinTable[tableAddr];
  end

endmodule

`default_nettype wire

//--- design/complexMixer.sv
// ------------------------------
// Complex mixer
// Two-stage multiply, shift, saturate
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module complexMixer
  import carrierLoopPkg::*;
#(
  parameter int SAMPLE_WIDTH = 18
) (
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      sampleValid,
  input  wire cplxSample sampleIn,
  input  wire cplxSample lo,
  output cplxSample      sampleOut,
  output logic           sampleOutValid
);

  localparam int PROD_WIDTH = 2 * SAMPLE_WIDTH;
  localparam int SHIFT      = SAMPLE_WIDTH - 1;
  localparam logic signed [PROD_WIDTH:0] SAT_MAX = (1 <<< (SAMPLE_WIDTH - 1)) - 1;
  localparam logic signed [PROD_WIDTH:0] SAT_MIN = -(1 <<< (SAMPLE_WIDTH - 1));

  logic signed [PROD_WIDTH-1:0] prodII, prodQQ, prodIQ, prodQI;
  logic signed [PROD_WIDTH:0]   sumI, sumQ;
  logic                         stage1Valid;

  function automatic logic signed [SAMPLE_WIDTH-1:0] shiftSat(
      input logic signed [PROD_WIDTH:0] x);
    logic signed [PROD_WIDTH:0] shifted;
    shifted = x >>> SHIFT;
    if (shifted > SAT_MAX) return SAT_MAX[SAMPLE_WIDTH-1:0];
    else if (shifted < SAT_MIN) return SAT_MIN[SAMPLE_WIDTH-1:0];
    else return shifted[SAMPLE_WIDTH-1:0];
  endfunction

  // Stage 1 full products
  always_ff @(posedge clk) begin
    prodII <= sampleIn.i * lo.i;
    prodQQ <= sampleIn.q * lo.q;
    prodIQ <= sampleIn.i * lo.q;
    prodQI <= sampleIn.q * lo.i;
  end

  assign sumI = prodII - prodQQ;
  assign sumQ = prodIQ + prodQI;

  // Stage 2 combine and scale back to sample width
  always_ff @(posedge clk) begin
    sampleOut.i <= shiftSat(sumI);
    sampleOut.q <= shiftSat(sumQ);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stage1Valid    <= 1'b0;
      sampleOutValid <= 1'b0;
    end else begin
      stage1Valid    <= sampleValid;
      sampleOutValid <= stage1Valid;
    end
  end

endmodule

`default_nettype wire

//--- design/carrierLoop.sv
// ------------------------------
// Carrier recovery loop top level
// Registers, loop filter, lock, NCO and mixer
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module carrierLoop
  import carrierLoopPkg::*;
#(
  parameter int SAMPLE_WIDTH = 18,
  parameter int TABLE_BITS   = 10
) (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       symEn,
  input  wire logic       sampleValid,
  input  wire logic [7:0] phaseError,
  input  wire cplxSample  sampleIn,
  input  wire axiLiteReq  axiReq,
  output axiLiteRsp       axiRsp,
  output cplxSample       sampleOut,
  output logic            sampleOutValid
);

  wire loopConfig cfg;
  wire loopStatus status;
  wire cplxSample lo;

  loopRegs regs (
    .clk    (clk),
    .reset  (reset),
    .axiReq (axiReq),
    .axiRsp (axiRsp),
    .status (status),
    .cfg    (cfg)
  );

  // Filter and lock detector share the symbol strobe
  loopFilter filter (
    .clk          (clk),
    .reset        (reset),
    .symEn        (symEn),
    .phaseError   (phaseError),
    .cfg          (cfg),
    .lagAccumHigh (status.lagAccumHigh),
    .freqWord     (status.freqWord)
  );

  lockDetector lockDet (
    .clk           (clk),
    .reset         (reset),
    .symEn         (symEn),
    .phaseError    (phaseError),
    .lockCount     (cfg.lockCount),
    .syncThreshold (cfg.syncThreshold),
    .carrierLock   (status.carrierLock)
  );

  ncoDds #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH),
    .TABLE_BITS   (TABLE_BITS)
  ) nco (
    .clk      (clk),
    .reset    (reset),
    .freqWord (status.freqWord),
    .lo       (lo)
  );

  complexMixer #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH)
  ) mixer (
    .clk            (clk),
    .reset          (reset),
    .sampleValid    (sampleValid),
    .sampleIn       (sampleIn),
    .lo             (lo),
    .sampleOut      (sampleOut),
    .sampleOutValid (sampleOutValid)
  );

endmodule

`default_nettype wire

//--- sim/tbCarrierLoop.sv
// ------------------------------
// Carrier loop testbench
// Case-file driven, cycle-based reference model
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module tbCarrierLoop
  import carrierLoopPkg::*;
;

  logic clk, reset, symEn, sampleValid;
  logic [7:0] phaseError;
  cplxSample sampleIn, sampleOut, mOut;
  axiLiteReq axiReq;
  axiLiteRsp axiRsp;
  logic sampleOutValid;

  // Reference model state and register mirror
  logic [31:0] ctrlR, gainsR, limitR, lockR;
  logic [31:0] mPhase, mFreq, lcgState;
  logic signed [39:0] mAcc;
  logic [15:0] mCount;
  logic mLock, mValid1, mValid2;
  longint mPII, mPQQ, mPIQ, mPQI, mLoI, mLoQ;
  int cosT [1024];
  int sinT [1024];
  int stallCycles, budget, fd;
  logic budgetReady;
  logic [8*16-1:0] curName;

  always #5 clk = ~clk;

  carrierLoop #(.SAMPLE_WIDTH(18), .TABLE_BITS(10)) dut (
    .clk(clk), .reset(reset), .symEn(symEn), .sampleValid(sampleValid),
    .phaseError(phaseError), .sampleIn(sampleIn), .axiReq(axiReq), .axiRsp(axiRsp),
    .sampleOut(sampleOut), .sampleOutValid(sampleOutValid)
  );

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int roundHalfAway(input real x);
    if (x >= 0.0) return $rtoi(x + 0.5);
    else return $rtoi(x - 0.5);
  endfunction

  function automatic logic signed [17:0] scaleSaturate(input longint x);
    longint y;
    y = x >>> 17;
    if (y > 131071) return 18'sd131071;
    else if (y < -131072) return -18'sd131072;
    else return y[17:0];
  endfunction

  function automatic logic [31:0] modelRegRead(input logic [7:0] addr);
    case (addr)
      8'h00: return ctrlR;
      8'h04: return gainsR;
      8'h08: return limitR;
      8'h0C: return lockR;
      8'h10: return {31'b0, mLock};
      8'h14: return mAcc[39:8];
      8'h18: return mFreq;
      default: return 32'h0;
    endcase
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic checkSample(input logic [8*16-1:0] name, input cplxSample exp,
                             input cplxSample act);
    if (exp !== act) begin
      $display("** Error %0s: expected i=%0d q=%0d, actual i=%0d q=%0d",
               name, exp.i, exp.q, act.i, act.q);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkWord(input logic [8*16-1:0] name, input logic [31:0] exp,
                           input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error %0s: expected %08h, actual %08h", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkResp(input logic [8*16-1:0] name, input logic [1:0] exp,
                           input logic [1:0] act);
    if (exp !== act) begin
      $display("** Error %0s: expected response %0d, actual %0d", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // ------------------------------
  // AXI4-Lite master tasks
  // ------------------------------
  task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    logic awGo, wGo;
    logic [31:0] mask;
    logic [31:0] merged;
    @(posedge clk);
    #1;
    axiReq.awaddr  = addr;
    axiReq.wdata   = data;
    axiReq.wstrb   = strb;
    axiReq.awvalid = 1'b1;
    axiReq.wvalid  = 1'b1;
    while (axiReq.awvalid || axiReq.wvalid) begin
      @(negedge clk);
      awGo = axiRsp.awready && axiReq.awvalid;
      wGo  = axiRsp.wready && axiReq.wvalid;
      @(posedge clk);
      #1;
      if (awGo) axiReq.awvalid = 1'b0;
      if (wGo) axiReq.wvalid = 1'b0;
    end
    repeat (stallCycles) begin
      @(posedge clk);
      #1;
    end
    axiReq.bready = 1'b1;
    do @(negedge clk); while (!axiRsp.bvalid);
    checkResp(curName, AXI_OKAY, axiRsp.bresp);
    @(posedge clk);
    #1;
    axiReq.bready = 1'b0;
    // Mirror keeps the byte-merged value of the implemented bits
    mask = (addr == 8'h00) ? 32'h7 : (addr == 8'h04) ? 32'h1F1F :
           (addr == 8'h08) ? 32'hFFFF_FFFF : 32'h00FF_FFFF;
    merged = modelRegRead(addr);
    for (int b = 0; b < 4; b++) if (strb[b]) merged[8*b +: 8] = data[8*b +: 8];
    merged &= mask;
    case (addr)
      8'h00: ctrlR = merged;
      8'h04: gainsR = merged;
      8'h08: limitR = merged;
      8'h0C: lockR = merged;
      default: ;
    endcase
  endtask

  task automatic axiRead(input logic [7:0] addr, output logic [31:0] data);
    logic arGo;
    @(posedge clk);
    #1;
    axiReq.araddr  = addr;
    axiReq.arvalid = 1'b1;
    arGo = 1'b0;
    while (!arGo) begin
      @(negedge clk);
      arGo = axiRsp.arready;
      @(posedge clk);
      #1;
    end
    axiReq.arvalid = 1'b0;
    repeat (stallCycles) begin
      @(posedge clk);
      #1;
    end
    axiReq.rready = 1'b1;
    do @(negedge clk); while (!axiRsp.rvalid);
    checkResp(curName, AXI_OKAY, axiRsp.rresp);
    data = axiRsp.rdata;
    @(posedge clk);
    #1;
    axiReq.rready = 1'b0;
  endtask

  // ------------------------------
  // Reference model, one step per clock
  // ------------------------------
  always @(posedge clk) begin : refModel
    logic signed [7:0] eAdj;
    logic signed [39:0] eExt, lead, accSum, newAcc, sumAll;
    longint sumL, limL;
    int mag;
    mOut.i = scaleSaturate(mPII - mPQQ);
    mOut.q = scaleSaturate(mPIQ + mPQI);
    mPII = longint'(sampleIn.i) * mLoI;
    mPQQ = longint'(sampleIn.q) * mLoQ;
    mPIQ = longint'(sampleIn.i) * mLoQ;
    mPQI = longint'(sampleIn.q) * mLoI;
    mLoI = cosT[mPhase[31:22]];
    mLoQ = sinT[mPhase[31:22]];
    if (reset) begin
      mPhase = 0;
      mFreq = 0;
      mAcc = 0;
      mLock = 0;
      mCount = 0;
      mValid1 = 0;
      mValid2 = 0;
    end else begin
      mPhase  = mPhase + mFreq;
      mValid2 = mValid1;
      mValid1 = sampleValid;
      eAdj = ctrlR[1] ? 8'sd0 : ctrlR[0] ? 8'sd0 - $signed(phaseError) : $signed(phaseError);
      eExt = eAdj;
      lead = eExt <<< gainsR[4:0];
      accSum = mAcc + (eExt <<< gainsR[12:8]);
      sumL = longint'(accSum);
      limL = longint'(limitR) * 256;
      if (sumL > limL) newAcc = limL[39:0];
      else if (sumL < -limL) newAcc = 40'(-limL);
      else newAcc = accSum;
      if (ctrlR[2]) newAcc = 0;
      sumAll = newAcc + lead;
      if (symEn || ctrlR[2]) mAcc = newAcc;
      if (symEn) begin
        mFreq = sumAll[39:8];
        mag = phaseError[7] ? 256 - phaseError : phaseError;
        if (mag > lockR[23:16]) begin
          if (mCount == 0) begin
            mLock = 0;
            mCount = lockR[15:0];
          end else mCount = mCount - 1;
        end else begin
          if (mCount == 16'hFFFF) begin
            mLock = 1;
            mCount = lockR[15:0];
          end else mCount = mCount + 1;
        end
      end
    end
  end

  // Output monitor, compared away from the clock edge
  always @(negedge clk) begin
    if (!reset) begin
      if (sampleOutValid !== mValid2)
        stopWithFailure($sformatf("Output valid flag out of step in case %0s", curName));
      if (mValid2) checkSample(curName, mOut, sampleOut);
    end
  end

  // Watchdog sized from the cases file
  initial begin
    wait (budgetReady);
    repeat (budget + 1000) @(posedge clk);
    stopWithFailure("Simulation timed out before all cases finished");
  end

  task automatic openCases();
    fd = $fopen("sim/carrierLoopCases.txt", "r");
    if (fd == 0) stopWithFailure("Cannot open the cases file");
  endtask

  // Reads one case line, skipping comment lines
  task automatic readCase(output logic [8*16-1:0] op, output logic [31:0] a,
                          output logic [31:0] b, output logic [31:0] c, output int ok);
    logic [8*200-1:0] rest;
    int n;
    ok = 0;
    while (!ok && !$feof(fd)) begin
      n = $fscanf(fd, "%s", curName);
      if (n != 1) break;
      if (curName == "#") n = $fgets(rest, fd);
      else begin
        n = $fscanf(fd, " %s %h %h %h", op, a, b, c);
        ok = (n == 4);
      end
    end
  endtask

  initial begin : mainFlow
    logic [8*16-1:0] op;
    logic [31:0] a, b, c, rdata;
    int ok;
    clk = 0;
    reset = 1;
    symEn = 0;
    sampleValid = 0;
    phaseError = 0;
    sampleIn = '0;
    axiReq = '0;
    ctrlR = 0;
    gainsR = 0;
    limitR = 0;
    lockR = 0;
    mPII = 0;
    mPQQ = 0;
    mPIQ = 0;
    mPQI = 0;
    mLoI = 0;
    mLoQ = 0;
    lcgState = 32'h98a6_b53d;
    stallCycles = 0;
    budget = 16;
    budgetReady = 0;
    for (int k = 0; k < 1024; k++) begin
      cosT[k] = roundHalfAway(131071.0 * $cos(2.0 * 3.14159265358979323846 * k / 1024.0));
      sinT[k] = roundHalfAway(131071.0 * $sin(2.0 * 3.14159265358979323846 * k / 1024.0));
    end
    // First pass only sizes the watchdog
    openCases();
    readCase(op, a, b, c, ok);
    while (ok) begin
      if (op == "idle" || op == "run") budget += a;
      else if (op == "sym") budget += b + 2;
      else if (op == "stl") stallCycles = a;
      else budget += 30 + 2 * stallCycles + 10;
      readCase(op, a, b, c, ok);
    end
    $fclose(fd);
    stallCycles = 0;
    budgetReady = 1;
    repeat (16) @(posedge clk);
    #1;
    reset = 0;
    openCases();
    readCase(op, a, b, c, ok);
    while (ok) begin
      if (op == "wr") axiWrite(a[7:0], b, c[3:0]);
      else if (op == "rd") begin
        axiRead(a[7:0], rdata);
        checkWord(curName, b, rdata);
      end else if (op == "rm") begin
        axiRead(a[7:0], rdata);
        checkWord(curName, modelRegRead(a[7:0]), rdata);
      end else if (op == "stl") stallCycles = a;
      else if (op == "sym") begin
        @(posedge clk);
        #1;
        symEn = 1;
        phaseError = a[7:0];
        repeat (b) begin
          @(posedge clk);
          #1;
        end
        symEn = 0;
      end else if (op == "smp") begin
        @(posedge clk);
        #1;
        sampleValid = 1;
        sampleIn.i = a[17:0];
        sampleIn.q = b[17:0];
        @(posedge clk);
        #1;
        sampleValid = 0;
      end else if (op == "run") begin
        repeat (a) begin
          @(posedge clk);
          #1;
          lcgState = lcgNext(lcgState);
          sampleIn.i = lcgState[31:14];
          lcgState = lcgNext(lcgState);
          sampleIn.q = lcgState[31:14];
          sampleValid = 1;
        end
        @(posedge clk);
        #1;
        sampleValid = 0;
      end else if (op == "idle") repeat (a) @(posedge clk);
      else stopWithFailure($sformatf("Unknown operation %0s in the cases file", op));
      readCase(op, a, b, c, ok);
    end
    $fclose(fd);
    repeat (8) @(posedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/carrierLoopCases.txt
# name op a b c, all values hex. wr addr data strb; rd addr expected; rm addr (model value)
# sym error count; smp i q; run count (LCG samples); idle count; stl stall cycles
regs wr 04 ffffffff 1
regs rd 04 0000001f 0
regs wr 04 ffffffff 2
regs rd 04 00001f1f 0
regs wr 08 12345678 5
regs rd 08 00340078 0
regs wr 20 ffffffff f
regs rd 20 00000000 0
regs rd 1c 00000000 0
stall stl 5 0 0
stall wr 0c 00abcdef f
stall rd 0c 00abcdef 0
stall rm 10 0 0
stall stl 0 0 0
passthru smp 00100 3ff00 0
passthru smp 1ffff 20000 0
passthru rm 18 0 0
filter wr 08 00000100 f
filter wr 04 00000402 f
filter sym 10 1 0
filter sym 7f 1 0
filter sym 80 1 0
filter rm 14 0 0
filter rm 18 0 0
invert wr 00 00000001 1
invert sym 30 1 0
invert rm 18 0 0
clamp wr 04 00000a00 f
clamp sym 7f 2 0
clamp rm 14 0 0
clamp rm 18 0 0
zero wr 00 00000002 1
zero sym 55 1 0
zero rm 18 0 0
clear wr 00 00000004 1
clear idle 3 0 0
clear rm 14 0 0
clear wr 00 00000000 1
lock wr 0c 0005fffc f
lock sym 40 c 0
lock wr 0c 00050002 f
lock sym 01 1e 0
lock rm 10 0 0
unlock sym 40 28 0
unlock rm 10 0 0
rotate wr 04 00000010 f
rotate sym 20 1 0
rotate rm 18 0 0
rotate run c8 0 0
rotate idle 5 0 0

//--- project.f
design/carrierLoopPkg.sv
design/loopRegs.sv
design/loopFilter.sv
design/lockDetector.sv
design/ncoDds.sv
design/complexMixer.sv
design/carrierLoop.sv
sim/tbCarrierLoop.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the carrier loop testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tbCarrierLoop -f project.f \
  -o simCarrierLoop > build.log 2>&1 \
  && ./obj_dir/simCarrierLoop > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
